// ==== Bender.yml ====
package:
  name: issue_queue

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tomasulo_pkg.sv
      - hdl/iq_fifo.sv
      - hdl/dispatch_ctrl.sv
      - hdl/issue_queue.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verification/issue_queue_chk.sv
      - verification/issue_queue_tb.sv

// ==== hdl/dispatch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "iq_settings.svh"

module dispatch_ctrl
    import tomasulo_pkg::*;
(
    input  wire logic rst_n_i,

    // decoder request and queue state
    input  wire logic ld_i,
    input  wire logic q_full_i,
    input  wire logic head_valid_i,
    input  wire op_t  head_op_i,

    // unit free flags
    input  wire logic res1_empty_i,
    input  wire logic res2_empty_i,
    input  wire logic res3_empty_i,
    input  wire logic res4_empty_i,
    input  wire logic resbr_empty_i,
    input  wire logic lsq_empty_i,
    input  wire logic rob_full_i,

    output logic      ack_o,
    output logic      push_o,
    output logic      pop_o,
    output logic      rob_load_o,
    output logic      regfile_allocate_o,
    output logic      res1_load_o,
    output logic      res2_load_o,
    output logic      res3_load_o,
    output logic      res4_load_o,
    output logic      resbr_load_o,
    output logic      lsq_load_o
);

    logic       is_branch;
    logic       is_store;
    logic       is_load;
    logic [3:0] res_free;
    logic [3:0] res_pick;
    logic [3:0] res_load;

    // class decode of the head entry
    assign is_branch = (head_op_i == `OP_BRANCH);
    assign is_store  = (head_op_i >= `OP_STORE_LO) && (head_op_i <= `OP_STORE_HI);
    assign is_load   = (head_op_i >= `OP_LOAD_LO);

    // accept while there is room and the stage is out of reset
    assign ack_o  = ld_i & ~q_full_i & rst_n_i;
    assign push_o = ack_o;

    // isolate the lowest free arithmetic station
    assign res_free = {res4_empty_i, res3_empty_i, res2_empty_i, res1_empty_i};
    assign res_pick = res_free & (~res_free + 4'd1);

    always_comb begin
        res_load           = '0;
        resbr_load_o       = 1'b0;
        lsq_load_o         = 1'b0;
        regfile_allocate_o = 1'b0;

        // nothing leaves the queue while the ROB has no room
        if (head_valid_i && !rob_full_i) begin
            if (is_branch) begin
                resbr_load_o = resbr_empty_i;
            end else if (is_store || is_load) begin
                lsq_load_o = lsq_empty_i;
                // only loads write a destination register
                regfile_allocate_o = lsq_empty_i & is_load;
            end else begin
                res_load           = res_pick;
                regfile_allocate_o = |res_pick;
            end
        end
    end

    assign res1_load_o = res_load[0];
    assign res2_load_o = res_load[1];
    assign res3_load_o = res_load[2];
    assign res4_load_o = res_load[3];

    // every dispatch pops both queues and claims a ROB slot
    assign pop_o      = |res_load | resbr_load_o | lsq_load_o;
    assign rob_load_o = pop_o;

endmodule : dispatch_ctrl

`default_nettype wire

// ==== hdl/iq_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "iq_settings.svh"

module iq_fifo
    import tomasulo_pkg::*;
#(
    parameter int unsigned WIDTH = 32
) (
    input  wire logic             clk,
    input  wire logic             rst_n_i,

    // write side
    input  wire logic             push_i,
    input  wire logic [WIDTH-1:0] data_i,

    // read side
    input  wire logic             pop_i,
    output logic                  full_o,
    output logic                  valid_o,
    output logic [WIDTH-1:0]      data_o
);

    // entry storage
    logic [WIDTH-1:0] mem [`IQ_DEPTH];

    iq_ptr_t rd_ptr;
    iq_ptr_t wr_ptr;
    iq_cnt_t count;

    // advance a pointer with wrap at the last entry
    function automatic iq_ptr_t next_ptr(input iq_ptr_t ptr);
        iq_ptr_t nxt;
        if (ptr == iq_ptr_t'(`IQ_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= next_ptr(rd_ptr);
            end

            // push and pop together leave the occupancy unchanged
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    assign full_o  = (count == iq_cnt_t'(`IQ_DEPTH));
    assign valid_o = (count != '0);

    // an empty queue shows zero so idle outputs carry no stale entry
    always_comb begin
        if (valid_o) begin
            data_o = mem[rd_ptr];
        end else begin
            data_o = '0;
        end
    end

endmodule : iq_fifo

`default_nettype wire

// ==== hdl/iq_settings.svh ====
`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// entries held by each of the two issue queues
`define IQ_DEPTH 8

// operation class width
`define OP_W 4

// data word and PC width
`define XLEN 32

// operation class codes
// 0 is the branch class, 1 to 7 are arithmetic
`define OP_BRANCH 4'd0

// stores occupy 8 to 10
`define OP_STORE_LO 4'd8
`define OP_STORE_HI 4'd10

// loads occupy 11 up to the top code
`define OP_LOAD_LO 4'd11

`endif

// ==== hdl/issue_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "iq_settings.svh"

module issue_queue
    import tomasulo_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n_i,

    // decoder side
    input  wire logic    ld_i,
    input  wire op_t     op_i,
    input  wire reg_t    src1_reg_i,
    input  wire logic    src1_valid_i,
    input  wire reg_t    src2_reg_i,
    input  wire logic    src2_valid_i,
    input  wire word_t   src2_data_i,
    input  wire funct3_t funct3_i,
    input  wire logic    funct7_i,
    input  wire word_t   next_pc_i,
    input  wire word_t   instr_i,
    input  wire word_t   instr_pc_i,
    output logic         ack_o,

    // unit readiness
    input  wire logic    res1_empty_i,
    input  wire logic    res2_empty_i,
    input  wire logic    res3_empty_i,
    input  wire logic    res4_empty_i,
    input  wire logic    resbr_empty_i,
    input  wire logic    lsq_empty_i,
    input  wire logic    rob_full_i,

    // dispatch strobes
    output logic         rob_load_o,
    output logic         regfile_allocate_o,
    output logic         res1_load_o,
    output logic         res2_load_o,
    output logic         res3_load_o,
    output logic         res4_load_o,
    output logic         resbr_load_o,
    output logic         lsq_load_o,

    // head entry fields
    output op_t          op_o,
    output reg_t         src1_reg_o,
    output logic         src1_valid_o,
    output reg_t         src2_reg_o,
    output logic         src2_valid_o,
    output word_t        src2_data_o,
    output funct3_t      funct3_o,
    output logic         funct7_o,
    output word_t        next_pc_o,
    output word_t        instr_o,
    output word_t        instr_pc_o
);

    logic [CTL_W-1:0]   ctl_wr;
    logic [CTL_W-1:0]   ctl_rd;
    logic [TRACE_W-1:0] trace_wr;
    logic [TRACE_W-1:0] trace_rd;
    logic               push;
    logic               pop;
    logic               ctl_full;
    logic               ctl_valid;

    // field order must match the split below
    assign ctl_wr = {op_i, src1_reg_i, src1_valid_i, src2_reg_i, src2_valid_i,
                     src2_data_i, funct3_i, funct7_i, next_pc_i};
    assign {op_o, src1_reg_o, src1_valid_o, src2_reg_o, src2_valid_o,
            src2_data_o, funct3_o, funct7_o, next_pc_o} = ctl_rd;

    assign trace_wr             = {instr_i, instr_pc_i};
    assign {instr_o, instr_pc_o} = trace_rd;

    iq_fifo #(.WIDTH(CTL_W)) u_ctl_q (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (push),
        .data_i  (ctl_wr),
        .pop_i   (pop),
        .full_o  (ctl_full),
        .valid_o (ctl_valid),
        .data_o  (ctl_rd)
    );

    // moves in step with the control queue, so its flags are not needed
    iq_fifo #(.WIDTH(TRACE_W)) u_trace_q (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (push),
        .data_i  (trace_wr),
        .pop_i   (pop),
        .full_o  (),
        .valid_o (),
        .data_o  (trace_rd)
    );

    dispatch_ctrl u_dispatch (
        .rst_n_i            (rst_n_i),
        .ld_i               (ld_i),
        .q_full_i           (ctl_full),
        .head_valid_i       (ctl_valid),
        .head_op_i          (op_o),
        .res1_empty_i       (res1_empty_i),
        .res2_empty_i       (res2_empty_i),
        .res3_empty_i       (res3_empty_i),
        .res4_empty_i       (res4_empty_i),
        .resbr_empty_i      (resbr_empty_i),
        .lsq_empty_i        (lsq_empty_i),
        .rob_full_i         (rob_full_i),
        .ack_o              (ack_o),
        .push_o             (push),
        .pop_o              (pop),
        .rob_load_o         (rob_load_o),
        .regfile_allocate_o (regfile_allocate_o),
        .res1_load_o        (res1_load_o),
        .res2_load_o        (res2_load_o),
        .res3_load_o        (res3_load_o),
        .res4_load_o        (res4_load_o),
        .resbr_load_o       (resbr_load_o),
        .lsq_load_o         (lsq_load_o)
    );

endmodule : issue_queue

`default_nettype wire

// ==== hdl/tomasulo_pkg.sv ====
`default_nettype none

`include "iq_settings.svh"

package tomasulo_pkg;

    // operation class as written by the decoder
    typedef logic [`OP_W-1:0] op_t;

    // architectural register tag, x0 to x31
    typedef logic [4:0] reg_t;

    // data word, instruction word or PC
    typedef logic [`XLEN-1:0] word_t;

    // funct3 field of the instruction
    typedef logic [2:0] funct3_t;

    // queue read and write pointers
    typedef logic [$clog2(`IQ_DEPTH)-1:0] iq_ptr_t;

    // queue occupancy, one wider so that a full queue fits
    typedef logic [$clog2(`IQ_DEPTH+1)-1:0] iq_cnt_t;

    // packed width of one control queue entry
    // op, two tags with valid bits, src2 data, funct3, funct7 and next PC
    localparam int unsigned CTL_W = $bits(op_t)
                                  + 2 * $bits(reg_t)
                                  + 2
                                  + $bits(word_t)
                                  + $bits(funct3_t)
                                  + 1
                                  + $bits(word_t);

    // trace queue entry holds the instruction word and its PC
    localparam int unsigned TRACE_W = 2 * $bits(word_t);

endpackage : tomasulo_pkg

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/tomasulo_pkg.sv
hdl/iq_fifo.sv
hdl/dispatch_ctrl.sv
hdl/issue_queue.sv
verification/issue_queue_chk.sv
verification/issue_queue_tb.sv

// ==== verification/issue_queue_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_queue_chk (
    input wire logic clk,
    input wire logic rst_n_i,
    input wire logic ack_i,
    input wire logic ctl_full_i,
    input wire logic ctl_valid_i,
    input wire logic trace_valid_i,
    input wire logic rob_load_i,
    input wire logic res1_load_i,
    input wire logic res2_load_i,
    input wire logic res3_load_i,
    input wire logic res4_load_i,
    input wire logic resbr_load_i,
    input wire logic lsq_load_i
);

    logic [5:0]  unit_loads;
    int unsigned fail_count = 0;

    assign unit_loads = {lsq_load_i, resbr_load_i, res4_load_i,
                         res3_load_i, res2_load_i, res1_load_i};

    // a head entry goes to one unit only
    a_one_unit: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(unit_loads))
        else begin
            fail_count++;
            $error("more than one unit load strobe is high");
        end

    // the ROB slot is claimed on every dispatch and only then
    a_rob_mirror: assert property (@(posedge clk) disable iff (!rst_n_i)
        rob_load_i == (|unit_loads))
        else begin
            fail_count++;
            $error("rob_load_o differs from the OR of the unit loads");
        end

    a_no_ack_full: assert property (@(posedge clk)
        !(ack_i && ctl_full_i))
        else begin
            fail_count++;
            $error("ack_o raised while the control queue is full");
        end

    // both queues hold the same number of entries
    a_valid_agree: assert property (@(posedge clk) disable iff (!rst_n_i)
        ctl_valid_i == trace_valid_i)
        else begin
            fail_count++;
            $error("control and trace queue valid flags disagree");
        end

endmodule : issue_queue_chk

`default_nettype wire

// ==== verification/issue_queue_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "iq_settings.svh"

module issue_queue_tb
    import tomasulo_pkg::*;
;

    localparam int CLK_PERIOD    = 40;
    localparam int HOLD_CYCLES   = 6;
    localparam int PRIO_CYCLES   = 64;
    localparam int ROB_HOLD      = 10;
    localparam int RANDOM_CYCLES = 240;
    // reset, fill, routing, priority, back-pressure and random run with their drains
    localparam int TOTAL_CYCLES  = 10 + 32 + 14 + PRIO_CYCLES + 12 + 30
                                 + RANDOM_CYCLES + 14;

    typedef struct {
        op_t     op;
        reg_t    src1_reg;
        logic    src1_valid;
        reg_t    src2_reg;
        logic    src2_valid;
        word_t   src2_data;
        funct3_t funct3;
        logic    funct7;
        word_t   next_pc;
        word_t   instr;
        word_t   instr_pc;
    } entry_t;

    logic    clk = 1'b0;
    logic    rst_n_i;
    logic    ld_i;
    op_t     op_i;
    reg_t    src1_reg_i;
    logic    src1_valid_i;
    reg_t    src2_reg_i;
    logic    src2_valid_i;
    word_t   src2_data_i;
    funct3_t funct3_i;
    logic    funct7_i;
    word_t   next_pc_i;
    word_t   instr_i;
    word_t   instr_pc_i;
    logic    ack_o;
    logic    res1_empty_i;
    logic    res2_empty_i;
    logic    res3_empty_i;
    logic    res4_empty_i;
    logic    resbr_empty_i;
    logic    lsq_empty_i;
    logic    rob_full_i;
    logic    rob_load_o;
    logic    regfile_allocate_o;
    logic    res1_load_o;
    logic    res2_load_o;
    logic    res3_load_o;
    logic    res4_load_o;
    logic    resbr_load_o;
    logic    lsq_load_o;
    op_t     op_o;
    reg_t    src1_reg_o;
    logic    src1_valid_o;
    reg_t    src2_reg_o;
    logic    src2_valid_o;
    word_t   src2_data_o;
    funct3_t funct3_o;
    logic    funct7_o;
    word_t   next_pc_o;
    word_t   instr_o;
    word_t   instr_pc_o;

    // expected contents of the stage, oldest first
    entry_t  model_q[$];

    issue_queue u_dut (.*);

    bind issue_queue issue_queue_chk u_chk (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ack_i         (ack_o),
        .ctl_full_i    (ctl_full),
        .ctl_valid_i   (ctl_valid),
        .trace_valid_i (u_trace_q.valid_o),
        .rob_load_i    (rob_load_o),
        .res1_load_i   (res1_load_o),
        .res2_load_i   (res2_load_o),
        .res3_load_i   (res3_load_o),
        .res4_load_i   (res4_load_o),
        .resbr_load_i  (resbr_load_o),
        .lsq_load_i    (lsq_load_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // strobes as {allocate, rob, lsq, resbr, res4, res3, res2, res1}
    function automatic logic [7:0] expected_strobes(
        input logic head_valid, input op_t op, input logic [3:0] res_free,
        input logic resbr_free, input logic lsq_free, input logic rob_full);
        logic [7:0] s;
        s = '0;
        if (head_valid && !rob_full) begin
            if (op == `OP_BRANCH) begin
                s[4] = resbr_free;
            end else if (op >= `OP_STORE_LO) begin
                // stores and loads share the load/store queue
                s[5] = lsq_free;
                s[7] = lsq_free && (op >= `OP_LOAD_LO);
            end else begin
                // scan downwards so the lowest free station is kept
                for (int i = 3; i >= 0; i--) begin
                    if (res_free[i]) begin
                        s[3:0] = 4'b0001 << i;
                    end
                end
                s[7] = |res_free;
            end
            s[6] = |s[5:0];
        end
        return s;
    endfunction

    function automatic entry_t sample_inputs();
        entry_t e;
        e.op         = op_i;
        e.src1_reg   = src1_reg_i;
        e.src1_valid = src1_valid_i;
        e.src2_reg   = src2_reg_i;
        e.src2_valid = src2_valid_i;
        e.src2_data  = src2_data_i;
        e.funct3     = funct3_i;
        e.funct7     = funct7_i;
        e.next_pc    = next_pc_i;
        e.instr      = instr_i;
        e.instr_pc   = instr_pc_i;
        return e;
    endfunction

    task automatic check_cycle();
        entry_t     head;
        logic       head_valid;
        logic       exp_ack;
        logic [7:0] exp_s;
        head_valid = (model_q.size() != 0);
        if (head_valid) begin
            head = model_q[0];
        end else begin
            head = '{default: '0};
        end
        exp_ack = rst_n_i && ld_i && (model_q.size() < `IQ_DEPTH);
        exp_s = expected_strobes(head_valid, head.op,
                                 {res4_empty_i, res3_empty_i, res2_empty_i, res1_empty_i},
                                 resbr_empty_i, lsq_empty_i, rob_full_i);
        check_value("checker assertion failures", 32'd0, u_dut.u_chk.fail_count);
        check_value("ack_o", exp_ack, ack_o);
        check_value("res1_load_o", exp_s[0], res1_load_o);
        check_value("res2_load_o", exp_s[1], res2_load_o);
        check_value("res3_load_o", exp_s[2], res3_load_o);
        check_value("res4_load_o", exp_s[3], res4_load_o);
        check_value("resbr_load_o", exp_s[4], resbr_load_o);
        check_value("lsq_load_o", exp_s[5], lsq_load_o);
        check_value("rob_load_o", exp_s[6], rob_load_o);
        check_value("regfile_allocate_o", exp_s[7], regfile_allocate_o);
        check_value("op_o", head.op, op_o);
        check_value("src1_reg_o", head.src1_reg, src1_reg_o);
        check_value("src1_valid_o", head.src1_valid, src1_valid_o);
        check_value("src2_reg_o", head.src2_reg, src2_reg_o);
        check_value("src2_valid_o", head.src2_valid, src2_valid_o);
        check_value("src2_data_o", head.src2_data, src2_data_o);
        check_value("funct3_o", head.funct3, funct3_o);
        check_value("funct7_o", head.funct7, funct7_o);
        check_value("next_pc_o", head.next_pc, next_pc_o);
        check_value("instr_o", head.instr, instr_o);
        check_value("instr_pc_o", head.instr_pc, instr_pc_o);

        // what the coming rising edge does to the stage
        if (!rst_n_i) begin
            model_q.delete();
        end else begin
            if (exp_s[6]) begin
                model_q.delete(0);
            end
            if (exp_ack) begin
                model_q.push_back(sample_inputs());
            end
        end
    endtask

    // outputs are settled 10 ns before each rising edge
    always @(negedge clk) begin
        #10;
        check_cycle();
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: the run hung, a handshake or drain never completed");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    function automatic entry_t random_entry(input op_t op);
        entry_t e;
        e.op         = op;
        e.src1_reg   = reg_t'($urandom);
        e.src1_valid = 1'($urandom);
        e.src2_reg   = reg_t'($urandom);
        e.src2_valid = 1'($urandom);
        e.src2_data  = word_t'($urandom);
        e.funct3     = funct3_t'($urandom);
        e.funct7     = 1'($urandom);
        e.instr      = word_t'($urandom);
        e.instr_pc   = word_t'($urandom) & 32'hffff_fffc;
        e.next_pc    = e.instr_pc + 32'd4;
        return e;
    endfunction

    task automatic drive_entry(input entry_t e);
        op_i         = e.op;
        src1_reg_i   = e.src1_reg;
        src1_valid_i = e.src1_valid;
        src2_reg_i   = e.src2_reg;
        src2_valid_i = e.src2_valid;
        src2_data_i  = e.src2_data;
        funct3_i     = e.funct3;
        funct7_i     = e.funct7;
        next_pc_i    = e.next_pc;
        instr_i      = e.instr;
        instr_pc_i   = e.instr_pc;
    endtask

    task automatic set_flags(input logic [3:0] res_free, input logic resbr_free,
                             input logic lsq_free, input logic rob_full);
        res1_empty_i  = res_free[0];
        res2_empty_i  = res_free[1];
        res3_empty_i  = res_free[2];
        res4_empty_i  = res_free[3];
        resbr_empty_i = resbr_free;
        lsq_empty_i   = lsq_free;
        rob_full_i    = rob_full;
    endtask

    // called at a falling edge with the request driven, returns at the edge after ack
    task automatic wait_accept();
        logic accepted;
        do begin
            #10;
            accepted = ack_o;
            @(negedge clk);
        end while (!accepted);
    endtask

    task automatic send_instr(input entry_t e);
        drive_entry(e);
        ld_i = 1'b1;
        wait_accept();
    endtask

    task automatic drain();
        ld_i = 1'b0;
        set_flags(4'b1111, 1'b1, 1'b1, 1'b0);
        while (model_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic random_traffic(input int cycles, input logic arith_only);
        logic pending;
        pending = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            if (arith_only) begin
                // every eighth cycle all arithmetic stations are busy
                set_flags((n % 8 == 7) ? 4'b0000 : 4'($urandom), 1'b1, 1'b1, 1'b0);
            end else begin
                set_flags(4'($urandom), 1'($urandom), 1'($urandom),
                          $urandom_range(0, 3) == 0);
            end
            // a request stays unchanged until it has been acknowledged
            if (!pending) begin
                ld_i = 1'($urandom);
                if (arith_only) begin
                    drive_entry(random_entry(op_t'($urandom_range(1, 7))));
                end else begin
                    drive_entry(random_entry(op_t'($urandom)));
                end
            end
            #10;
            pending = ld_i && !ack_o;
            @(negedge clk);
        end
        if (pending) begin
            set_flags(4'b1111, 1'b1, 1'b1, 1'b0);
            wait_accept();
        end
        ld_i = 1'b0;
    endtask

    initial begin
        int   fill_acks;
        logic accepted;
        void'($urandom(32'h05d4_c0ab));
        rst_n_i  = 1'b0;
        ld_i     = 1'b0;
        drive_entry('{default: '0});
        set_flags(4'b0000, 1'b0, 1'b0, 1'b0);

        // a request during reset must not be taken
        repeat (2) @(negedge clk);
        drive_entry(random_entry(op_t'(3)));
        ld_i = 1'b1;
        repeat (3) @(negedge clk);
        ld_i = 1'b0;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
        repeat (2) @(negedge clk);

        // fill with every unit busy while the request stays raised
        fill_acks = 0;
        ld_i = 1'b1;
        drive_entry(random_entry(op_t'($urandom)));
        for (int i = 0; i < `IQ_DEPTH + HOLD_CYCLES; i++) begin
            #10;
            accepted = ack_o;
            @(negedge clk);
            if (accepted) begin
                fill_acks++;
                drive_entry(random_entry(op_t'($urandom)));
            end
        end
        check_value("acks while filling", `IQ_DEPTH, fill_acks);
        set_flags(4'b1111, 1'b1, 1'b1, 1'b0);
        wait_accept();
        drain();

        // branch, store, load and arithmetic with all units free
        send_instr(random_entry(`OP_BRANCH));
        send_instr(random_entry(`OP_STORE_LO));
        send_instr(random_entry(`OP_LOAD_LO));
        send_instr(random_entry(op_t'(5)));
        drain();

        random_traffic(PRIO_CYCLES, 1'b1);
        drain();

        // ROB full holds everything in order
        set_flags(4'b1111, 1'b1, 1'b1, 1'b1);
        for (int i = 0; i < 5; i++) begin
            send_instr(random_entry(op_t'($urandom)));
        end
        ld_i = 1'b0;
        repeat (ROB_HOLD) @(negedge clk);
        drain();

        random_traffic(RANDOM_CYCLES, 1'b0);
        drain();

        repeat (2) @(negedge clk);
        if (u_dut.u_chk.fail_count != 0) begin
            $display("the bound checker saw %0d assertion failures",
                     u_dut.u_chk.fail_count);
            $display("ERRORS FOUND");
            $fatal(1, "assertion failures");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule : issue_queue_tb

`default_nettype wire
